//--- boot_rom.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// boot rom
// byte rom from rom_image.hex, registered read and strobe
// --------------------

module boot_rom #(
	parameter int	ADDR_W = 5
)(
	input	logic				clk_pixel,
	input	logic				cs_n,
	input	logic				rd_n,
	input	logic	[ADDR_W-1:0]	addr,		// low bits only, region wraps
	output	logic	[7:0]		rdata,
	output	logic				rdata_en
);
	logic	[7:0]	mem [0:( 1 << ADDR_W ) - 1];
	logic	[7:0]	ff_rdata;
	logic			ff_rdata_en;

	initial begin
		$readmemh( "rom_image.hex", mem );
	end

	always_ff @( posedge clk_pixel ) begin
		if( !cs_n && !rd_n ) begin
			ff_rdata <= mem[addr];
		end
	end

	// strobe tracks the read, one clock late
	always_ff @( posedge clk_pixel ) begin
		ff_rdata_en <= !cs_n && !rd_n;
	end

	assign rdata	= ff_rdata;
	assign rdata_en	= ff_rdata_en;
endmodule

`default_nettype wire

//--- compile.f
labo_pkg.sv
labo_bus_fabric.sv
gpio_port.sv
boot_rom.sv
work_ram.sv
video_timing.sv
labo_top.sv
tb_clock_gen.sv
tb_labo_top.sv

//--- gpio_port.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// gpio port
// i/o mapped, 8-bit output latch and 8-bit input read
// --------------------

module gpio_port
	import labo_pkg::*;
#(
	parameter logic [7:0]	IO_ADDR = 8'h10
)(
	input	logic			clk_pixel,
	input	logic			ff_reset_n,
	input	cpu_bus_t		cpu_bus,
	input	logic	[7:0]	gpi,
	output	logic	[7:0]	q,
	output	logic			q_en,
	output	logic	[7:0]	gpo
);
	logic			w_sel;
	logic	[7:0]	ff_q;
	logic			ff_q_en;
	logic	[7:0]	ff_gpo;

	// z80 puts the port number on a[7:0]
	assign w_sel	= !cpu_bus.iorq_n && ( cpu_bus.addr[7:0] == IO_ADDR );

	// --------------------
	// output latch
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_gpo <= 8'h00;
		end
		else if( w_sel && !cpu_bus.wr_n ) begin
			ff_gpo <= cpu_bus.wdata;
		end
	end

	// --------------------
	// input read
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_q_en <= 1'b0;
		end
		else begin
			ff_q_en <= w_sel && !cpu_bus.rd_n;		// one clock behind the read
		end
	end

	always_ff @( posedge clk_pixel ) begin
		if( w_sel && !cpu_bus.rd_n ) begin
			ff_q <= gpi;							// sampled with the strobe
		end
	end

	assign q		= ff_q;
	assign q_en		= ff_q_en;
	assign gpo		= ff_gpo;
endmodule

`default_nettype wire

//--- labo_bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// labo bus fabric
// memory region decode into rom and ram selects,
// read data register fed by all bus slaves
// --------------------

module labo_bus_fabric
	import labo_pkg::*;
(
	input	logic			clk_pixel,
	input	logic			ff_reset_n,
	input	cpu_bus_t		cpu_bus,
	output	logic			rom_cs_n,
	output	logic			ram_cs_n,
	input	logic	[7:0]	rom_rdata,
	input	logic			rom_rdata_en,
	input	logic	[7:0]	ram_rdata,
	input	logic			ram_rdata_en,
	input	logic	[7:0]	gpio_q,
	input	logic			gpio_q_en,
	output	logic	[7:0]	rdata
);
	mem_region_e	w_region;
	logic	[7:0]	ff_rdata;

	// --------------------
	// region decode
	// --------------------
	always_comb begin
		case( cpu_bus.addr[15:14] )
			2'b00:		w_region = REGION_ROM;
			2'b11:		w_region = REGION_RAM;
			default:	w_region = REGION_NONE;		// 4000h to bfffh
		endcase
	end

	// selects follow mreq_n inside their own region only
	assign rom_cs_n	= ( w_region == REGION_ROM ) ? cpu_bus.mreq_n : 1'b1;
	assign ram_cs_n	= ( w_region == REGION_RAM ) ? cpu_bus.mreq_n : 1'b1;

	// --------------------
	// read data register
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_rdata <= IDLE_RDATA;
		end
		else if( cpu_bus.rd_n ) begin
			ff_rdata <= IDLE_RDATA;			// bus released, float high
		end
		else if( rom_rdata_en ) begin
			ff_rdata <= rom_rdata;
		end
		else if( ram_rdata_en ) begin
			ff_rdata <= ram_rdata;
		end
		else if( gpio_q_en ) begin
			ff_rdata <= gpio_q;
		end
		else begin
			ff_rdata <= ff_rdata;			// hold for the rest of the cycle
		end
	end

	assign rdata	= ff_rdata;
endmodule

`default_nettype wire

//--- labo_pkg.sv
`default_nettype none
// --------------------
// labo shared definitions
// bus cycle and video structs, region and phase enums,
// colour bar table and idle bus value
// --------------------

package labo_pkg;

	// --------------------
	// cpu bus
	// --------------------
	typedef struct packed {
		logic			mreq_n;		// memory cycle
		logic			iorq_n;		// i/o cycle
		logic			rd_n;
		logic			wr_n;
		logic	[15:0]	addr;
		logic	[7:0]	wdata;		// write side of the data bus
	} cpu_bus_t;					// 28 bits

	// upper two address bits select the region
	typedef enum logic [1:0] {
		REGION_ROM	= 2'b00,		// 0000h to 3fffh
		REGION_NONE	= 2'b01,		// middle 32k, nothing mapped
		REGION_RAM	= 2'b11			// c000h to ffffh
	} mem_region_e;

	// value seen when no slave drives the bus
	localparam logic [7:0] IDLE_RDATA = 8'hFF;

	// --------------------
	// video
	// --------------------
	typedef struct packed {
		logic	hs;
		logic	vs;
		logic	de;
	} video_sync_t;

	typedef struct packed {
		logic	[7:0]	r;
		logic	[7:0]	g;
		logic	[7:0]	b;
	} rgb_t;

	// phases of one line, in scan order
	typedef enum logic [1:0] {
		HP_ACTIVE,
		HP_FRONT,
		HP_SYNC,
		HP_BACK
	} h_phase_e;

	// phases of one frame, in scan order
	typedef enum logic [1:0] {
		VP_ACTIVE,
		VP_FRONT,
		VP_SYNC,
		VP_BACK
	} v_phase_e;

	// bar i: bit 2 red, bit 1 green, bit 0 blue
	localparam rgb_t BAR_COLOURS [0:7] = '{
		24'h000000,		// black
		24'h0000FF,		// blue
		24'h00FF00,		// green
		24'h00FFFF,		// cyan
		24'hFF0000,		// red
		24'hFF00FF,		// magenta
		24'hFFFF00,		// yellow
		24'hFFFFFF		// white
	};

endpackage

`default_nettype wire

//--- labo_top.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// labo top
// bus fabric, gpio, boot rom, work ram and video timing
// --------------------

module labo_top
	import labo_pkg::*;
#(
	parameter logic [7:0]	GPIO_IO_ADDR	= 8'h10,
	parameter int			H_ACTIVE		= 1280,		// 720p
	parameter int			H_FRONT			= 110,
	parameter int			H_SYNC			= 40,
	parameter int			H_BACK			= 220,
	parameter int			V_ACTIVE		= 720,
	parameter int			V_FRONT			= 5,
	parameter int			V_SYNC			= 5,
	parameter int			V_BACK			= 20,
	parameter int			BAR_SHIFT		= 7,		// 128 pixel bars
	parameter int			ROM_ADDR_W		= 5,
	parameter int			RAM_ADDR_W		= 10
)(
	input	logic			clk_pixel,
	input	logic			ff_reset_n,
	input	cpu_bus_t		cpu_bus,
	input	logic	[1:0]	button,
	output	logic	[7:0]	rdata,
	output	logic	[7:0]	gpo,
	output	video_sync_t	video_sync,
	output	rgb_t			video_rgb
);
	logic			w_rom_cs_n;
	logic	[7:0]	w_rom_rdata;
	logic			w_rom_rdata_en;
	logic			w_ram_cs_n;
	logic	[7:0]	w_ram_rdata;
	logic			w_ram_rdata_en;
	logic	[7:0]	w_gpio_q;
	logic			w_gpio_q_en;

	// --------------------
	// bus side
	// --------------------
	labo_bus_fabric u_fabric (
		.clk_pixel		( clk_pixel			),
		.ff_reset_n		( ff_reset_n		),
		.cpu_bus		( cpu_bus			),
		.rom_cs_n		( w_rom_cs_n		),
		.ram_cs_n		( w_ram_cs_n		),
		.rom_rdata		( w_rom_rdata		),
		.rom_rdata_en	( w_rom_rdata_en	),
		.ram_rdata		( w_ram_rdata		),
		.ram_rdata_en	( w_ram_rdata_en	),
		.gpio_q			( w_gpio_q			),
		.gpio_q_en		( w_gpio_q_en		),
		.rdata			( rdata				)
	);

	gpio_port #(
		.IO_ADDR		( GPIO_IO_ADDR		)
	) u_gpio (
		.clk_pixel		( clk_pixel			),
		.ff_reset_n		( ff_reset_n		),
		.cpu_bus		( cpu_bus			),
		.gpi			( { 6'd0, button }	),		// buttons on bits 1:0
		.q				( w_gpio_q			),
		.q_en			( w_gpio_q_en		),
		.gpo			( gpo				)
	);

	boot_rom #(
		.ADDR_W			( ROM_ADDR_W		)
	) u_rom (
		.clk_pixel		( clk_pixel					),
		.cs_n			( w_rom_cs_n				),
		.rd_n			( cpu_bus.rd_n				),
		.addr			( cpu_bus.addr[ROM_ADDR_W-1:0]	),
		.rdata			( w_rom_rdata				),
		.rdata_en		( w_rom_rdata_en			)
	);

	work_ram #(
		.ADDR_W			( RAM_ADDR_W		)
	) u_ram (
		.clk_pixel		( clk_pixel					),
		.cs_n			( w_ram_cs_n				),
		.rd_n			( cpu_bus.rd_n				),
		.wr_n			( cpu_bus.wr_n				),
		.addr			( cpu_bus.addr[RAM_ADDR_W-1:0]	),
		.wdata			( cpu_bus.wdata				),
		.rdata			( w_ram_rdata				),
		.rdata_en		( w_ram_rdata_en			)
	);

	// --------------------
	// video
	// --------------------
	video_timing #(
		.H_ACTIVE		( H_ACTIVE			),
		.H_FRONT		( H_FRONT			),
		.H_SYNC			( H_SYNC			),
		.H_BACK			( H_BACK			),
		.V_ACTIVE		( V_ACTIVE			),
		.V_FRONT		( V_FRONT			),
		.V_SYNC			( V_SYNC			),
		.V_BACK			( V_BACK			),
		.BAR_SHIFT		( BAR_SHIFT			)
	) u_video (
		.clk_pixel		( clk_pixel			),
		.ff_reset_n		( ff_reset_n		),
		.video_sync		( video_sync		),
		.video_rgb		( video_rgb			)
	);
endmodule

`default_nettype wire

//--- rom_image.hex
// boot rom image, one byte per line, from address 00h up
F3
31
00
00
3E
01
D3
10
DB
10
E6
03
28
FA
07
D3
10
21
00
C0
77
23
7C
B7
20
FA
C3
04
00
76
00
FF

//--- run_sim.sh
#!/bin/sh
# build and run the labo testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_labo_top -o sim_labo
./obj_dir/sim_labo > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
grep -q "STATUS: PASS" sim.log

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// testbench clock and reset
// free running pixel clock, reset held low at start
// --------------------

module tb_clock_gen #(
	parameter int	PERIOD_NS		= 8,
	parameter int	RESET_CYCLES	= 5
)(
	output	logic	clk_pixel,
	output	logic	ff_reset_n
);
	initial begin
		clk_pixel = 1'b0;
		forever #( PERIOD_NS / 2 ) clk_pixel = ~clk_pixel;
	end

	// released just after an edge, like the other inputs
	initial begin
		ff_reset_n = 1'b0;
		repeat ( RESET_CYCLES ) @( posedge clk_pixel );
		#1;
		ff_reset_n = 1'b1;
	end
endmodule

`default_nettype wire

//--- tb_labo_top.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// labo top testbench
// plays bus master on the cpu strobes and checks rom, ram, gpio,
// unmapped space and the reduced video timing
// --------------------

module tb_labo_top
	import labo_pkg::*;
;
	// small video frame keeps the run short
	localparam int	H_ACTIVE	= 32;
	localparam int	H_FRONT		= 4;
	localparam int	H_SYNC		= 4;
	localparam int	H_BACK		= 8;
	localparam int	V_ACTIVE	= 6;
	localparam int	V_FRONT		= 1;
	localparam int	V_SYNC		= 2;
	localparam int	V_BACK		= 2;
	localparam int	BAR_SHIFT	= 2;
	localparam int	ROM_ADDR_W	= 5;
	localparam int	RAM_ADDR_W	= 10;
	localparam logic [7:0]	GPIO_PORT	= 8'h10;
	localparam int	H_TOTAL		= H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int	FRAME_CYC	= H_TOTAL * ( V_ACTIVE + V_FRONT + V_SYNC + V_BACK );

	// --------------------
	// run length
	// --------------------
	localparam int	READ_CYC	= 5;		// drive, 3 low cycles, release
	localparam int	WRITE_CYC	= 2;
	localparam int	TEST_CYC	= 10 + 64 * READ_CYC + 64 * ( WRITE_CYC + READ_CYC )
								+ 8 * ( WRITE_CYC + 1 ) + 25 * READ_CYC
								+ 4 * WRITE_CYC + 2 * FRAME_CYC;
	localparam int	TIMEOUT_CYC	= 2 * TEST_CYC;	// about 4000

	localparam cpu_bus_t	IDLE_BUS = '{mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1,
										wr_n: 1'b1, addr: 16'h0000, wdata: 8'h00};

	logic			clk_pixel;
	logic			ff_reset_n;
	cpu_bus_t		cpu_bus;
	logic	[1:0]	button;
	logic	[7:0]	rdata;
	logic	[7:0]	gpo;
	video_sync_t	video_sync;
	rgb_t			video_rgb;

	// reference state
	logic	[7:0]	rom_model [0:( 1 << ROM_ADDR_W ) - 1];
	logic	[7:0]	ram_shadow [0:( 1 << RAM_ADDR_W ) - 1];
	logic	[15:0]	ram_addr [0:63];	// addresses written in the ram test
	logic	[7:0]	gpo_model;
	logic	[31:0]	rng_state;
	int				n_checks	= 0;
	int				n_errors	= 0;
	int				cycle_cnt	= 0;

	tb_clock_gen #(
		.PERIOD_NS		( 8				),
		.RESET_CYCLES	( 5				)
	) u_clock (
		.clk_pixel		( clk_pixel		),
		.ff_reset_n		( ff_reset_n	)
	);

	labo_top #(
		.GPIO_IO_ADDR	( GPIO_PORT		),
		.H_ACTIVE		( H_ACTIVE		),
		.H_FRONT		( H_FRONT		),
		.H_SYNC			( H_SYNC		),
		.H_BACK			( H_BACK		),
		.V_ACTIVE		( V_ACTIVE		),
		.V_FRONT		( V_FRONT		),
		.V_SYNC			( V_SYNC		),
		.V_BACK			( V_BACK		),
		.BAR_SHIFT		( BAR_SHIFT		),
		.ROM_ADDR_W		( ROM_ADDR_W	),
		.RAM_ADDR_W		( RAM_ADDR_W	)
	) i_labo_top (
		.clk_pixel		( clk_pixel		),
		.ff_reset_n		( ff_reset_n	),
		.cpu_bus		( cpu_bus		),
		.button			( button		),
		.rdata			( rdata			),
		.gpo			( gpo			),
		.video_sync		( video_sync	),
		.video_rgb		( video_rgb		)
	);

	// --------------------
	// reference model
	// --------------------
	function automatic logic [31:0] lcg_step( input logic [31:0] s );
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] ref_read_value( input logic io, input logic [15:0] addr );
		logic	[7:0]	v;
		v = 8'hFF;										// nothing drives the bus
		if( io ) begin
			if( addr[7:0] == GPIO_PORT ) v = { 6'b000000, button };
		end
		else if( addr[15:14] == 2'b00 ) begin
			v = rom_model[addr[ROM_ADDR_W-1:0]];		// rom wraps in its region
		end
		else if( addr[15:14] == 2'b11 ) begin
			v = ram_shadow[addr[RAM_ADDR_W-1:0]];
		end
		return v;
	endfunction

	// bar index bits map straight to r, g, b
	function automatic rgb_t ref_pixel( input logic de, input int x );
		logic	[2:0]	bar;
		rgb_t			c;
		bar	= 3'( ( x >> BAR_SHIFT ) % 8 );
		c.r	= bar[2] ? 8'hFF : 8'h00;
		c.g	= bar[1] ? 8'hFF : 8'h00;
		c.b	= bar[0] ? 8'hFF : 8'h00;
		if( !de ) c = '0;								// black in blanking
		return c;
	endfunction

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_byte( input logic [7:0] got, input logic [7:0] exp, input string name );
		n_checks++;
		if( got !== exp ) begin
			n_errors++;
			$display( "FAIL %s: got %02h expected %02h", name, got, exp );
		end
	endtask

	task automatic check_rgb( input rgb_t got, input rgb_t exp, input string name );
		n_checks++;
		if( got !== exp ) begin
			n_errors++;
			$display( "FAIL %s: got %06h expected %06h", name, got, exp );
		end
	endtask

	task automatic check_sync( input video_sync_t got, input video_sync_t exp, input string name );
		n_checks++;
		if( got !== exp ) begin
			n_errors++;
			$display( "FAIL %s: got %01h expected %01h", name, got, exp );
		end
	endtask

	task automatic report_problem( input string msg );
		n_checks++;
		n_errors++;
		$display( "%s", msg );
	endtask

	task automatic report_test( input string name, input int checks0, input int errors0 );
		$display( "test %-9s checks %0d errors %0d", name, n_checks - checks0, n_errors - errors0 );
	endtask

	task automatic draw_random( output logic [31:0] r );
		rng_state	= lcg_step( rng_state );
		r			= rng_state;
	endtask

	// --------------------
	// bus master
	// --------------------
	task automatic bus_read( input logic io, input logic [15:0] addr, output logic [7:0] data );
		@( posedge clk_pixel );
		#1;
		cpu_bus.mreq_n	= io;
		cpu_bus.iorq_n	= !io;
		cpu_bus.addr	= addr;
		cpu_bus.rd_n	= 1'b0;
		repeat ( 2 ) @( posedge clk_pixel );
		@( negedge clk_pixel );							// end of third low cycle
		data = rdata;
		@( posedge clk_pixel );
		#1;
		cpu_bus = IDLE_BUS;
	endtask

	task automatic bus_write( input logic io, input logic [15:0] addr, input logic [7:0] data );
		@( posedge clk_pixel );
		#1;
		cpu_bus.mreq_n	= io;
		cpu_bus.iorq_n	= !io;
		cpu_bus.addr	= addr;
		cpu_bus.wdata	= data;
		cpu_bus.wr_n	= 1'b0;
		@( posedge clk_pixel );							// write lands here
		#1;
		cpu_bus = IDLE_BUS;
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic test_reset();
		int		c0;
		int		e0;
		c0 = n_checks;
		e0 = n_errors;
		repeat ( 3 ) @( negedge clk_pixel );				// still inside reset
		check_sync( video_sync, '0, "video_sync" );
		check_byte( rdata, 8'hFF, "rdata" );
		check_byte( gpo, 8'h00, "gpo" );
		wait ( ff_reset_n );
		report_test( "reset", c0, e0 );
	endtask

	task automatic test_rom();
		int				c0;
		int				e0;
		logic	[7:0]	d;
		logic	[15:0]	a;
		c0 = n_checks;
		e0 = n_errors;
		for( int i = 0; i < ( 1 << ROM_ADDR_W ); i++ ) begin
			a = 16'( i );
			bus_read( 1'b0, a, d );
			check_byte( d, ref_read_value( 1'b0, a ), "rdata" );
			bus_read( 1'b0, a + 16'h2000, d );			// alias higher in the region
			check_byte( d, ref_read_value( 1'b0, a + 16'h2000 ), "rdata" );
		end
		report_test( "rom", c0, e0 );
	endtask

	task automatic test_ram();
		int				c0;
		int				e0;
		logic	[31:0]	r;
		logic	[7:0]	d;
		logic	[15:0]	a;
		c0 = n_checks;
		e0 = n_errors;
		for( int i = 0; i < 64; i++ ) begin
			draw_random( r );
			ram_addr[i]	= { 2'b11, r[29:16] };
			ram_shadow[ram_addr[i][RAM_ADDR_W-1:0]] = r[7:0];
			bus_write( 1'b0, ram_addr[i], r[7:0] );
		end
		for( int i = 0; i < 64; i++ ) begin
			bus_read( 1'b0, ram_addr[i], d );
			check_byte( d, ref_read_value( 1'b0, ram_addr[i] ), "rdata" );
		end
		// i/o cycle at a ram address stays off the ram
		a = ram_addr[0];
		if( a[7:0] == GPIO_PORT ) a = a ^ 16'h0001;
		bus_read( 1'b1, a, d );
		check_byte( d, ref_read_value( 1'b1, a ), "rdata" );
		report_test( "ram", c0, e0 );
	endtask

	task automatic test_gpio();
		int				c0;
		int				e0;
		logic	[31:0]	r;
		logic	[7:0]	d;
		c0 = n_checks;
		e0 = n_errors;
		for( int i = 0; i < 8; i++ ) begin
			draw_random( r );
			gpo_model = r[15:8];
			bus_write( 1'b1, { r[31:24], GPIO_PORT }, gpo_model );	// upper byte is don't care
			@( negedge clk_pixel );
			check_byte( gpo, gpo_model, "gpo" );
		end
		for( int b = 0; b < 4; b++ ) begin
			draw_random( r );
			@( posedge clk_pixel );
			#1;
			button = 2'( b );
			bus_read( 1'b1, { r[23:16], GPIO_PORT }, d );
			check_byte( d, ref_read_value( 1'b1, { r[23:16], GPIO_PORT } ), "rdata" );
		end
		report_test( "gpio", c0, e0 );
	endtask

	task automatic test_unmapped();
		int				c0;
		int				e0;
		logic	[31:0]	r;
		logic	[7:0]	d;
		logic	[15:0]	a;
		c0 = n_checks;
		e0 = n_errors;
		for( int i = 0; i < 10; i++ ) begin
			draw_random( r );
			a			= r[31:16];
			a[15:14]	= r[5] ? 2'b01 : 2'b10;			// 4000h to bfffh
			bus_read( 1'b0, a, d );
			check_byte( d, ref_read_value( 1'b0, a ), "rdata" );
			a			= { r[15:8], r[23:16] };
			if( a[7:0] == GPIO_PORT ) a[7:0] = 8'h11;	// any other port
			bus_read( 1'b1, a, d );
			check_byte( d, ref_read_value( 1'b1, a ), "rdata" );
		end
		// same low bits as a ram location but outside the ram region
		a = { 2'b01, ram_addr[0][13:0] };
		bus_write( 1'b0, a, ~ram_shadow[ram_addr[0][RAM_ADDR_W-1:0]] );
		bus_read( 1'b0, ram_addr[0], d );
		check_byte( d, ref_read_value( 1'b0, ram_addr[0] ), "rdata" );
		bus_write( 1'b1, 16'h0020, ~gpo_model );
		@( negedge clk_pixel );
		check_byte( gpo, gpo_model, "gpo" );
		report_test( "unmapped", c0, e0 );
	endtask

	task automatic test_video();
		int				c0;
		int				e0;
		int				x;
		int				de_cnt;
		int				hs_w;
		int				hs_gap;
		int				vs_w;
		int				lines;
		int				hs_pulses;
		int				vs_pulses;
		logic			hs_seen;
		logic			vs_seen;
		video_sync_t	s;
		video_sync_t	prev;
		c0 = n_checks;
		e0 = n_errors;
		x = 0;
		de_cnt = 0;
		hs_w = 0;
		hs_gap = 0;
		vs_w = 0;
		lines = 0;
		hs_pulses = 0;
		vs_pulses = 0;
		hs_seen = 1'b0;
		vs_seen = 1'b0;
		@( negedge clk_pixel );
		while( video_sync.de ) begin					// start in blanking
			@( negedge clk_pixel );
		end
		prev = video_sync;
		for( int i = 0; i < 2 * FRAME_CYC; i++ ) begin
			@( negedge clk_pixel );
			s = video_sync;
			// de and pixel colour
			if( s.de && !prev.de ) begin
				x = 0;
				de_cnt = 0;
			end
			check_rgb( video_rgb, ref_pixel( s.de, x ), "video_rgb" );
			if( s.de ) begin
				x++;
				de_cnt++;
			end
			if( !s.de && prev.de ) begin
				lines++;
				if( de_cnt != H_ACTIVE )
					report_problem( $sformatf( "de high for %0d cycles in a line, expected %0d",
						de_cnt, H_ACTIVE ) );
			end
			// hs width and spacing
			if( s.hs && !prev.hs ) begin
				if( hs_seen && hs_gap != H_TOTAL )
					report_problem( $sformatf( "hs pulses %0d cycles apart, expected %0d",
						hs_gap, H_TOTAL ) );
				hs_seen = 1'b1;
				hs_gap = 0;
				hs_w = 0;
			end
			if( hs_seen ) hs_gap++;
			if( s.hs ) hs_w++;
			if( !s.hs && prev.hs && hs_seen ) begin
				hs_pulses++;
				if( hs_w != H_SYNC )
					report_problem( $sformatf( "hs high for %0d cycles, expected %0d",
						hs_w, H_SYNC ) );
			end
			// vs width in whole lines
			if( s.vs && !prev.vs ) begin
				vs_seen = 1'b1;
				vs_w = 0;
			end
			if( s.vs ) vs_w++;
			if( !s.vs && prev.vs && vs_seen ) begin
				vs_pulses++;
				if( vs_w != V_SYNC * H_TOTAL )
					report_problem( $sformatf( "vs high for %0d cycles (%0d lines), expected %0d lines",
						vs_w, vs_w / H_TOTAL, V_SYNC ) );
			end
			prev = s;
		end
		if( lines < V_ACTIVE || vs_pulses == 0 || hs_pulses < 2 * FRAME_CYC / H_TOTAL - 1 )
			report_problem( "video did not show a full frame of active lines, hs pulses and a vs pulse" );
		report_test( "video", c0, e0 );
	endtask

	// --------------------
	// run limit
	// --------------------
	always @( posedge clk_pixel ) begin
		cycle_cnt <= cycle_cnt + 1;
		if( cycle_cnt == TIMEOUT_CYC ) begin
			$display( "timeout: run still going after %0d cycles", TIMEOUT_CYC );
			$display( "STATUS: FAIL" );
			$finish;
		end
	end

	// --------------------
	// main sequence
	// --------------------
	initial begin
		cpu_bus		= IDLE_BUS;
		button		= 2'b00;
		gpo_model	= 8'h00;
		rng_state	= 32'hec7;
		$readmemh( "rom_image.hex", rom_model );
		test_reset();
		test_rom();
		test_ram();
		test_gpio();
		test_unmapped();
		test_video();
		$display( "checks %0d, errors %0d", n_checks, n_errors );
		if( n_errors == 0 ) begin
			$display( "STATUS: PASS" );
		end
		else begin
			$display( "STATUS: FAIL" );
		end
		$finish;
	end
endmodule

`default_nettype wire

//--- video_timing.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// video timing
// line and frame phase counters, registered sync and de,
// eight vertical colour bars over the active area
// --------------------

module video_timing
	import labo_pkg::*;
#(
	parameter int	H_ACTIVE	= 1280,
	parameter int	H_FRONT		= 110,
	parameter int	H_SYNC		= 40,
	parameter int	H_BACK		= 220,
	parameter int	V_ACTIVE	= 720,
	parameter int	V_FRONT		= 5,
	parameter int	V_SYNC		= 5,
	parameter int	V_BACK		= 20,
	parameter int	BAR_SHIFT	= 7
)(
	input	logic			clk_pixel,
	input	logic			ff_reset_n,
	output	video_sync_t	video_sync,
	output	rgb_t			video_rgb
);
	localparam int	H_TOTAL	= H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int	V_TOTAL	= V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int	H_CNT_W	= $clog2( H_TOTAL );
	localparam int	V_CNT_W	= $clog2( V_TOTAL );

	h_phase_e				ff_h_phase;
	v_phase_e				ff_v_phase;
	logic	[H_CNT_W-1:0]	ff_h_cnt;		// pixel x while active
	logic	[V_CNT_W-1:0]	ff_v_cnt;		// line y while active
	logic	[H_CNT_W-1:0]	w_h_end;
	logic	[V_CNT_W-1:0]	w_v_end;
	logic					w_h_last;
	logic					w_line_end;
	logic	[2:0]			w_bar;
	video_sync_t			ff_sync;
	rgb_t					ff_rgb;

	// last count of the current phase
	always_comb begin
		case( ff_h_phase )
			HP_ACTIVE:	w_h_end = H_CNT_W'( H_ACTIVE - 1 );
			HP_FRONT:	w_h_end = H_CNT_W'( H_FRONT - 1 );
			HP_SYNC:	w_h_end = H_CNT_W'( H_SYNC - 1 );
			default:	w_h_end = H_CNT_W'( H_BACK - 1 );
		endcase
		case( ff_v_phase )
			VP_ACTIVE:	w_v_end = V_CNT_W'( V_ACTIVE - 1 );
			VP_FRONT:	w_v_end = V_CNT_W'( V_FRONT - 1 );
			VP_SYNC:	w_v_end = V_CNT_W'( V_SYNC - 1 );
			default:	w_v_end = V_CNT_W'( V_BACK - 1 );
		endcase
	end

	assign w_h_last		= ( ff_h_cnt == w_h_end );
	assign w_line_end	= w_h_last && ( ff_h_phase == HP_BACK );

	// --------------------
	// horizontal fsm
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_h_phase	<= HP_ACTIVE;
			ff_h_cnt	<= '0;
		end
		else if( w_h_last ) begin
			ff_h_cnt	<= '0;
			case( ff_h_phase )
				HP_ACTIVE:	ff_h_phase <= HP_FRONT;
				HP_FRONT:	ff_h_phase <= HP_SYNC;
				HP_SYNC:	ff_h_phase <= HP_BACK;
				default:	ff_h_phase <= HP_ACTIVE;	// next line
			endcase
		end
		else begin
			ff_h_cnt	<= ff_h_cnt + 1'b1;
		end
	end

	// --------------------
	// vertical fsm
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_v_phase	<= VP_ACTIVE;
			ff_v_cnt	<= '0;
		end
		else if( w_line_end ) begin					// steps once per line
			if( ff_v_cnt == w_v_end ) begin
				ff_v_cnt	<= '0;
				case( ff_v_phase )
					VP_ACTIVE:	ff_v_phase <= VP_FRONT;
					VP_FRONT:	ff_v_phase <= VP_SYNC;
					VP_SYNC:	ff_v_phase <= VP_BACK;
					default:	ff_v_phase <= VP_ACTIVE;	// next frame
				endcase
			end
			else begin
				ff_v_cnt	<= ff_v_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// outputs
	// --------------------
	assign w_bar	= 3'( ff_h_cnt >> BAR_SHIFT );	// bar index from x

	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_sync	<= '0;
		end
		else begin
			ff_sync.de	<= ( ff_h_phase == HP_ACTIVE ) && ( ff_v_phase == VP_ACTIVE );
			ff_sync.hs	<= ( ff_h_phase == HP_SYNC );
			ff_sync.vs	<= ( ff_v_phase == VP_SYNC );
		end
	end

	// same edge as de, black in blanking
	always_ff @( posedge clk_pixel ) begin
		if( ( ff_h_phase == HP_ACTIVE ) && ( ff_v_phase == VP_ACTIVE ) ) begin
			ff_rgb	<= BAR_COLOURS[w_bar];
		end
		else begin
			ff_rgb	<= '0;
		end
	end

	assign video_sync	= ff_sync;
	assign video_rgb	= ff_rgb;
endmodule

`default_nettype wire

//--- work_ram.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// work ram
// single port byte ram, registered read with strobe
// --------------------

module work_ram #(
	parameter int	ADDR_W = 10
)(
	input	logic				clk_pixel,
	input	logic				cs_n,
	input	logic				rd_n,
	input	logic				wr_n,
	input	logic	[ADDR_W-1:0]	addr,		// aliases across the 16k region
	input	logic	[7:0]		wdata,
	output	logic	[7:0]		rdata,
	output	logic				rdata_en
);
	logic	[7:0]	mem [0:( 1 << ADDR_W ) - 1];
	logic	[7:0]	ff_rdata;
	logic			ff_rdata_en;

	// write port
	always_ff @( posedge clk_pixel ) begin
		if( !cs_n && !wr_n ) begin
			mem[addr] <= wdata;
		end
	end

	// read port
	always_ff @( posedge clk_pixel ) begin
		if( !cs_n && !rd_n ) begin
			ff_rdata <= mem[addr];
		end
	end

	always_ff @( posedge clk_pixel ) begin
		ff_rdata_en <= !cs_n && !rd_n;		// lines up with ff_rdata
	end

	assign rdata	= ff_rdata;
	assign rdata_en	= ff_rdata_en;
endmodule

`default_nettype wire
